//--- include/audio_playback_consts.svh
`ifndef AUDIO_PLAYBACK_CONSTS_SVH
`define AUDIO_PLAYBACK_CONSTS_SVH

// ---------------------------------------------------------------------
// data path widths
// ---------------------------------------------------------------------
`define SAMPLE_W    16    // signed pcm sample
`define WORD_ADDR_W 18    // sample index into memory
`define AXI_ADDR_W  32    // byte address on the read bus

`define BCLK_DIV    4     // clk cycles per half bclk period

// ---------------------------------------------------------------------
// voice register map and pan bits
// ---------------------------------------------------------------------
`define REG_START   0
`define REG_LENGTH  1
`define REG_LOOP    2
`define REG_PAN     3
`define REG_ENABLE  4
`define PAN_LEFT    0
`define PAN_RIGHT   1

`endif

//--- hw/audio_pkg.sv
`include "audio_playback_consts.svh"

package audio_pkg;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;
    typedef logic [`WORD_ADDR_W-1:0]     word_addr_t;
    typedef logic [`AXI_ADDR_W-1:0]      axi_addr_t;
    typedef logic [2:0]                  reg_sel_t;
    typedef logic [31:0]                 reg_data_t;
    typedef logic [1:0]                  pan_t;    // bit PAN_LEFT and bit PAN_RIGHT

    // idle waits for the frame strobe, hold is the stopped voice
    typedef enum logic [1:0] {
        idle,
        request,
        wait_data,
        hold
    } voice_state_t;

endpackage

//--- hw/voice_reader.sv
`timescale 1ns/10ps
`include "audio_playback_consts.svh"

module voice_reader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reg_we,
    input  audio_pkg::reg_sel_t  reg_sel,
    input  audio_pkg::reg_data_t reg_data,
    input  logic                 frame_strobe,
    input  logic                 arready,
    input  audio_pkg::sample_t   rdata,
    input  logic [1:0]           rresp,
    input  logic                 rvalid,
    output audio_pkg::axi_addr_t araddr,
    output logic                 arvalid,
    output logic                 rready,
    output audio_pkg::sample_t   voice_sample,
    output audio_pkg::pan_t      pan,
    output logic                 active
);
    import audio_pkg::*;

    word_addr_t   start_q;
    word_addr_t   length_q;
    logic         loop_q;
    pan_t         pan_q;
    voice_state_t state;
    word_addr_t   pos_q;
    word_addr_t   next_pos;
    word_addr_t   end_pos;
    axi_addr_t    araddr_q;
    sample_t      sample_q;
    logic         active_q;
    logic         last_q;
    logic         wr_enable;
    logic         beat;

    // ---------------------------------------------------------------------
    // register file
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reg_we && reg_sel == reg_sel_t'(`REG_START))
            start_q <= reg_data[`WORD_ADDR_W-1:0];
        if (reg_we && reg_sel == reg_sel_t'(`REG_LENGTH))
            length_q <= reg_data[`WORD_ADDR_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            loop_q <= 1'b0;
            pan_q  <= '0;
        end else if (reg_we) begin
            if (reg_sel == reg_sel_t'(`REG_LOOP))
                loop_q <= reg_data[0];
            if (reg_sel == reg_sel_t'(`REG_PAN))
                pan_q <= reg_data[1:0];
        end
    end

    assign wr_enable = reg_we && (reg_sel == reg_sel_t'(`REG_ENABLE));
    assign beat      = rvalid && (state == wait_data);
    assign next_pos  = pos_q + 1'b1;
    assign end_pos   = start_q + length_q;    // first index past the region

    // ---------------------------------------------------------------------
    // fetch state machine
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= hold;
            active_q <= 1'b0;
            last_q   <= 1'b0;
            sample_q <= '0;
            pos_q    <= '0;
        end else begin
            case (state)
                idle: if (frame_strobe) begin
                    if (last_q) begin    // last sample went out with this frame
                        state    <= hold;
                        active_q <= 1'b0;
                        last_q   <= 1'b0;
                        sample_q <= '0;
                    end else begin
                        state    <= request;
                        araddr_q <= axi_addr_t'({pos_q, 1'b0});
                    end
                end
                request: if (arready)
                    state <= wait_data;
                wait_data: if (beat) begin
                    if (!active_q) begin    // stopped while the read was in flight
                        state <= hold;
                    end else if (rresp == 2'b00) begin
                        state    <= idle;
                        sample_q <= rdata;
                        if (next_pos != end_pos) begin
                            pos_q <= next_pos;
                        end else if (loop_q) begin
                            pos_q <= start_q;
                        end else begin
                            pos_q  <= next_pos;
                            last_q <= 1'b1;
                        end
                    end else begin
                        state    <= hold;
                        active_q <= 1'b0;
                        sample_q <= '0;
                    end
                end
                default: ;
            endcase

            // an open read is always finished before the voice leaves it
            if (wr_enable) begin
                last_q <= 1'b0;
                if (reg_data[0]) begin
                    active_q <= 1'b1;
                    pos_q    <= start_q;
                    if (state == idle || state == hold)
                        state <= idle;
                end else begin
                    active_q <= 1'b0;
                    sample_q <= '0;
                    if (state == idle || state == hold)
                        state <= hold;
                end
            end
        end
    end

    assign araddr       = araddr_q;
    assign arvalid      = (state == request);
    assign rready       = (state == wait_data);
    assign voice_sample = sample_q;
    assign pan          = pan_q;
    assign active       = active_q;

endmodule

//--- hw/sample_mixer.sv
`timescale 1ns/10ps
`include "audio_playback_consts.svh"

module sample_mixer (
    input  audio_pkg::sample_t voice0_sample,
    input  audio_pkg::sample_t voice1_sample,
    input  audio_pkg::pan_t    voice0_pan,
    input  audio_pkg::pan_t    voice1_pan,
    output audio_pkg::sample_t left,
    output audio_pkg::sample_t right
);
    import audio_pkg::*;

    logic [`SAMPLE_W:0] left_sum;    // one guard bit for the overflow check
    logic [`SAMPLE_W:0] right_sum;

    // top two bits differ only when the sum left the 16-bit range
    function automatic sample_t clip(input logic [`SAMPLE_W:0] sum);
        case (sum[`SAMPLE_W -: 2])
            2'b01:   clip = {1'b0, {(`SAMPLE_W-1){1'b1}}};
            2'b10:   clip = {1'b1, {(`SAMPLE_W-1){1'b0}}};
            default: clip = sum[`SAMPLE_W-1:0];
        endcase
    endfunction

    always_comb begin
        left_sum  = '0;
        right_sum = '0;
        if (voice0_pan[`PAN_LEFT])
            left_sum = left_sum + {voice0_sample[`SAMPLE_W-1], voice0_sample};
        if (voice1_pan[`PAN_LEFT])
            left_sum = left_sum + {voice1_sample[`SAMPLE_W-1], voice1_sample};
        if (voice0_pan[`PAN_RIGHT])
            right_sum = right_sum + {voice0_sample[`SAMPLE_W-1], voice0_sample};
        if (voice1_pan[`PAN_RIGHT])
            right_sum = right_sum + {voice1_sample[`SAMPLE_W-1], voice1_sample};
    end

    assign left  = clip(left_sum);
    assign right = clip(right_sum);

endmodule

//--- hw/i2s_transmitter.sv
`timescale 1ns/10ps
`include "audio_playback_consts.svh"

module i2s_transmitter (
    input  logic               clk,
    input  logic               rst,
    input  audio_pkg::sample_t left,
    input  audio_pkg::sample_t right,
    output logic               bclk,
    output logic               lrclk,
    output logic               dout,
    output logic               frame_strobe
);
    import audio_pkg::*;

    logic [7:0]                   div_cnt;
    logic                         bclk_q;
    logic                         half_done;
    logic                         bclk_fall;
    logic [4:0]                   bit_cnt;    // bit 4 selects the right word
    logic [2*$bits(sample_t)-1:0] shift_q;

    // ---------------------------------------------------------------------
    // bit clock
    // ---------------------------------------------------------------------
    assign half_done = (div_cnt == 8'(`BCLK_DIV - 1));
    assign bclk_fall = half_done && bclk_q;    // bclk goes low on this edge

    always_ff @(posedge clk) begin
        if (!rst) begin
            div_cnt <= '0;
            bclk_q  <= 1'b0;
        end else if (half_done) begin
            div_cnt <= '0;
            bclk_q  <= ~bclk_q;
        end else begin
            div_cnt <= div_cnt + 8'd1;
        end
    end

    // ---------------------------------------------------------------------
    // frame shifter
    // ---------------------------------------------------------------------
    // strobe marks the edge into bit 0, the mixer output is taken there
    assign frame_strobe = bclk_fall && (bit_cnt == 5'd31);

    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt <= '0;
            shift_q <= '0;
        end else if (bclk_fall) begin
            bit_cnt <= bit_cnt + 5'd1;
            if (frame_strobe)
                shift_q <= {left, right};    // left word goes out first
            else
                shift_q <= {shift_q[$bits(shift_q)-2:0], 1'b0};
        end
    end

    assign bclk  = bclk_q;
    assign lrclk = bit_cnt[4];
    assign dout  = shift_q[$bits(shift_q)-1];

endmodule

//--- hw/audio_playback_top.sv
`timescale 1ns/10ps

module audio_playback_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reg_we,
    input  logic                 voice_sel,
    input  audio_pkg::reg_sel_t  reg_sel,
    input  audio_pkg::reg_data_t reg_data,
    output audio_pkg::axi_addr_t m0_araddr,
    output logic                 m0_arvalid,
    input  logic                 m0_arready,
    input  audio_pkg::sample_t   m0_rdata,
    input  logic [1:0]           m0_rresp,
    input  logic                 m0_rvalid,
    output logic                 m0_rready,
    output audio_pkg::axi_addr_t m1_araddr,
    output logic                 m1_arvalid,
    input  logic                 m1_arready,
    input  audio_pkg::sample_t   m1_rdata,
    input  logic [1:0]           m1_rresp,
    input  logic                 m1_rvalid,
    output logic                 m1_rready,
    output logic                 bclk,
    output logic                 lrclk,
    output logic                 dout,
    output logic                 voice0_active,
    output logic                 voice1_active
);
    import audio_pkg::*;

    logic    voice0_we;
    logic    voice1_we;
    logic    frame_strobe;
    sample_t voice0_sample;
    sample_t voice1_sample;
    pan_t    voice0_pan;
    pan_t    voice1_pan;
    sample_t left;
    sample_t right;

    assign voice0_we = reg_we && !voice_sel;
    assign voice1_we = reg_we && voice_sel;

    // ---------------------------------------------------------------------
    // voices
    // ---------------------------------------------------------------------
    voice_reader voice0_i (
        .clk(clk), .rst(rst), .reg_we(voice0_we), .reg_sel(reg_sel), .reg_data(reg_data),
        .frame_strobe(frame_strobe), .arready(m0_arready), .rdata(m0_rdata),
        .rresp(m0_rresp), .rvalid(m0_rvalid), .araddr(m0_araddr), .arvalid(m0_arvalid),
        .rready(m0_rready), .voice_sample(voice0_sample), .pan(voice0_pan),
        .active(voice0_active)
    );

    voice_reader voice1_i (
        .clk(clk), .rst(rst), .reg_we(voice1_we), .reg_sel(reg_sel), .reg_data(reg_data),
        .frame_strobe(frame_strobe), .arready(m1_arready), .rdata(m1_rdata),
        .rresp(m1_rresp), .rvalid(m1_rvalid), .araddr(m1_araddr), .arvalid(m1_arvalid),
        .rready(m1_rready), .voice_sample(voice1_sample), .pan(voice1_pan),
        .active(voice1_active)
    );

    sample_mixer mixer_i (
        .voice0_sample(voice0_sample), .voice1_sample(voice1_sample),
        .voice0_pan(voice0_pan), .voice1_pan(voice1_pan), .left(left), .right(right)
    );

    i2s_transmitter i2s_i (
        .clk(clk), .rst(rst), .left(left), .right(right), .bclk(bclk), .lrclk(lrclk),
        .dout(dout), .frame_strobe(frame_strobe)
    );

endmodule

//--- verification/audio_playback_asserts.sv
`timescale 1ns/10ps

module audio_playback_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 arvalid,
    input logic                 arready,
    input audio_pkg::axi_addr_t araddr,
    input logic                 bclk,
    input logic                 lrclk,
    input logic                 frame_strobe
);
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr moved before arready");

    lr_on_fall: assert property (@(posedge clk) disable iff (!rst)
        $changed(lrclk) |-> $fell(bclk))    // word select moves with the data bits
        else $error("lrclk changed away from a falling bclk edge");

    strobe_pulse: assert property (@(posedge clk) disable iff (!rst)
        frame_strobe |=> !frame_strobe)
        else $error("frame_strobe high for more than one cycle");
endmodule

bind voice_reader audio_playback_asserts voice_chk_i (
    .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .bclk(1'b0), .lrclk(1'b0), .frame_strobe(frame_strobe)
);

bind i2s_transmitter audio_playback_asserts i2s_chk_i (
    .clk(clk), .rst(rst), .arvalid(1'b0), .arready(1'b0), .araddr(32'd0),
    .bclk(bclk), .lrclk(lrclk), .frame_strobe(frame_strobe)
);

//--- verification/audio_playback_tb.sv
`timescale 1ns/10ps
`include "audio_playback_consts.svh"

// AXI-Lite read slave port whose arready and rvalid come after 0 to 8 cycles
module axi_read_responder (
    input  logic                 clk,
    input  audio_pkg::axi_addr_t araddr,
    input  logic                 arvalid,
    input  logic                 rready,
    output logic                 arready,
    output logic                 rvalid,
    output logic [7:0]           word_idx,
    output logic                 rready_lost
);
    int hold_cnt;

    initial begin
        arready     = 1'b0;
        rvalid      = 1'b0;
        word_idx    = '0;
        rready_lost = 1'b0;
        forever begin
            @(negedge clk);
            if (arvalid) begin
                repeat ($urandom_range(8)) @(negedge clk);
                arready  = 1'b1;
                word_idx = araddr[8:1];    // byte address back to word index
                @(negedge clk);
                arready = 1'b0;
                repeat ($urandom_range(8)) @(negedge clk);
                rvalid   = 1'b1;
                hold_cnt = 0;
                while (!rready && hold_cnt < 16) begin    // rvalid stays up until rready
                    @(negedge clk);
                    hold_cnt++;
                end
                if (!rready) begin
                    rready_lost = 1'b1;
                    $display("rready did not rise within 16 cycles of rvalid at %0t", $time);
                end
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end
endmodule

module audio_playback_tb;
    import audio_pkg::*;

    localparam int ERR_BOUND = 200;    // words at and above answer with SLVERR

    logic clk, rst, reg_we, voice_sel;
    reg_sel_t reg_sel;
    reg_data_t reg_data;
    axi_addr_t m0_araddr, m1_araddr;
    logic m0_arvalid, m0_arready, m0_rvalid, m0_rready;
    logic m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    sample_t m0_rdata, m1_rdata;
    logic [1:0] m0_rresp, m1_rresp;
    logic [7:0] m0_idx, m1_idx;
    logic m0_lost, m1_lost;
    logic bclk, lrclk, dout, voice0_active, voice1_active;
    logic [15:0] mem [256];
    logic [31:0] frames [$];    // received {left, right} pairs
    logic [15:0] rx_word, rx_left;
    logic rx_lr;
    int rx_cnt;
    int errors, checks;

    audio_playback_top dut_i (.*);

    axi_read_responder port0_i (.clk(clk), .araddr(m0_araddr), .arvalid(m0_arvalid),
        .rready(m0_rready), .arready(m0_arready), .rvalid(m0_rvalid), .word_idx(m0_idx),
        .rready_lost(m0_lost));
    axi_read_responder port1_i (.clk(clk), .araddr(m1_araddr), .arvalid(m1_arvalid),
        .rready(m1_rready), .arready(m1_arready), .rvalid(m1_rvalid), .word_idx(m1_idx),
        .rready_lost(m1_lost));

    assign m0_rdata = mem[m0_idx];
    assign m1_rdata = mem[m1_idx];
    assign m0_rresp = (int'(m0_idx) >= ERR_BOUND) ? 2'b10 : 2'b00;
    assign m1_rresp = (int'(m1_idx) >= ERR_BOUND) ? 2'b10 : 2'b00;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ---------------------------------------------------------------------
    // I2S receiver
    // ---------------------------------------------------------------------
    initial begin
        rx_lr  = 1'b0;
        rx_cnt = 0;
    end

    always @(posedge bclk) begin
        if (lrclk != rx_lr)    // a new word starts where lrclk changes
            rx_cnt = 0;
        rx_lr   = lrclk;
        rx_word = {rx_word[14:0], dout};
        rx_cnt  = rx_cnt + 1;
        if (rx_cnt == 16) begin
            if (lrclk)
                frames.push_back({rx_left, rx_word});
            else
                rx_left = rx_word;
            rx_cnt = 0;
        end
    end

    // ---------------------------------------------------------------------
    // helpers
    // ---------------------------------------------------------------------
    task automatic check(input int got, input int exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic voice, input int sel, input int data);
        @(negedge clk);
        voice_sel = voice;
        reg_sel   = reg_sel_t'(sel);
        reg_data  = reg_data_t'(data);
        reg_we    = 1'b1;
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    task automatic setup_voice(input logic voice, input int start, input int length,
                               input int loop, input int pan);
        write_reg(voice, `REG_START, start);
        write_reg(voice, `REG_LENGTH, length);
        write_reg(voice, `REG_LOOP, loop);
        write_reg(voice, `REG_PAN, pan);
        write_reg(voice, `REG_ENABLE, 1);
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cycles;
        target = frames.size() + n;
        cycles = 0;
        while (frames.size() < target && cycles < n * 256 + 512) begin
            @(negedge clk);
            cycles++;
        end
        if (frames.size() < target) begin
            errors++;
            $display("timeout at %0t: %0d of %0d I2S frames arrived", $time,
                     n - (target - frames.size()), n);
        end
    endtask

    task automatic stop_voices();
        write_reg(1'b0, `REG_ENABLE, 0);
        write_reg(1'b1, `REG_ENABLE, 0);
        wait_frames(2);    // lets a read in flight finish
    endtask

    function automatic int word(input int i, input bit right_side);
        if (i < 0 || i >= frames.size())
            return 32'h7fff_ffff;    // no 16-bit sample matches this
        return right_side ? $signed(frames[i][15:0]) : $signed(frames[i][31:16]);
    endfunction

    function automatic int first_sound(input bit right_side);
        int i;
        i = 0;
        while (i < frames.size() && word(i, right_side) == 0)
            i++;
        return i;
    endfunction

    function automatic int sat_add(input int a, input int b);
        if (a + b > 32767)
            return 32767;
        if (a + b < -32768)
            return -32768;
        return a + b;
    endfunction

    task automatic end_test(input string name, input int err0);
        $display("%-18s %s", name, (errors == err0) ? "passed" : "failed");
    endtask

    // ---------------------------------------------------------------------
    // tests
    // ---------------------------------------------------------------------
    task automatic test_reset_state();
        int err0;
        int busy;
        err0 = errors;
        busy = 0;
        check(int'(bclk), 0, "bclk after reset");
        check(int'(lrclk), 0, "lrclk after reset");
        check(int'(dout), 0, "dout after reset");
        repeat (600) begin
            @(negedge clk);
            if (m0_arvalid || m1_arvalid || m0_rready || m1_rready || dout ||
                voice0_active || voice1_active)
                busy++;
        end
        check(busy, 0, "cycles with arvalid, rready, dout or active high before any write");
        end_test("reset state", err0);
    endtask

    task automatic test_single_voice();
        int err0;
        int i;
        int k;
        err0 = errors;
        for (i = 0; i < 6; i++)
            mem[16 + i] = 16'((i + 1) * 1000 - 3500);
        frames.delete();
        setup_voice(1'b0, 16, 6, 0, 1 << `PAN_LEFT);
        wait_frames(12);
        k = first_sound(1'b0);
        for (i = 0; i < 6; i++)
            check(word(k + i, 1'b0), $signed(mem[16 + i]), "left word of one-shot voice");
        check(word(k + 6, 1'b0), 0, "left word after the region");
        for (i = 0; i < frames.size(); i++)
            check(word(i, 1'b1), 0, "right word of a left panned voice");
        check(int'(voice0_active), 0, "voice0_active after the region");
        stop_voices();
        end_test("single voice", err0);
    endtask

    task automatic test_looping();
        int err0;
        int i;
        int k;
        err0 = errors;
        mem[32] = 16'(7);
        mem[33] = 16'(-8);
        mem[34] = 16'(9000);
        frames.delete();
        setup_voice(1'b1, 32, 3, 1, 1 << `PAN_RIGHT);
        wait_frames(14);
        k = first_sound(1'b1);
        for (i = 0; i < 9; i++)
            check(word(k + i, 1'b1), $signed(mem[32 + i % 3]), "right word of looping voice");
        stop_voices();
        end_test("looping", err0);
    endtask

    task automatic test_mixing();
        int err0;
        int i;
        err0 = errors;
        for (i = 0; i < 4; i++) begin
            mem[48 + i] = 16'(30000);
            mem[64 + i] = 16'(10000);
        end
        frames.delete();
        setup_voice(1'b0, 48, 4, 1, 3);
        setup_voice(1'b1, 64, 4, 1, 3);
        wait_frames(8);
        check(word(frames.size() - 1, 1'b0), sat_add(30000, 10000), "left of 30000 + 10000");
        check(word(frames.size() - 1, 1'b1), sat_add(30000, 10000), "right of 30000 + 10000");
        for (i = 0; i < 4; i++)
            mem[48 + i] = 16'(-30000);
        frames.delete();
        wait_frames(6);
        check(word(frames.size() - 1, 1'b0), sat_add(-30000, 10000), "left of -30000 + 10000");
        check(word(frames.size() - 1, 1'b1), sat_add(-30000, 10000), "right of -30000 + 10000");
        stop_voices();
        end_test("mixing", err0);
    endtask

    task automatic test_read_error();
        int err0;
        int i;
        int k;
        err0 = errors;
        mem[ERR_BOUND - 3] = 16'(1111);
        mem[ERR_BOUND - 2] = 16'(-2222);
        mem[ERR_BOUND - 1] = 16'(3333);
        frames.delete();
        setup_voice(1'b0, ERR_BOUND - 3, 6, 0, 1 << `PAN_LEFT);
        wait_frames(10);
        k = first_sound(1'b0);
        for (i = 0; i < 3; i++)
            check(word(k + i, 1'b0), $signed(mem[ERR_BOUND - 3 + i]), "word below SLVERR");
        check(word(k + 3, 1'b0), 0, "left word after SLVERR");
        check(int'(voice0_active), 0, "voice0_active after SLVERR");
        stop_voices();
        end_test("read error", err0);
    endtask

    task automatic test_disable();
        int err0;
        int i;
        err0 = errors;
        setup_voice(1'b0, 48, 4, 1, 1 << `PAN_LEFT);
        setup_voice(1'b1, 64, 4, 1, 1 << `PAN_RIGHT);
        wait_frames(4);
        write_reg(1'b0, `REG_ENABLE, 0);
        frames.delete();
        wait_frames(3);
        for (i = 1; i < 3; i++)    // frame 0 was latched before the write
            check(word(i, 1'b0), 0, "left word after disabling voice 0");
        for (i = 0; i < 3; i++)
            check(word(i, 1'b1), 10000, "right word of the running voice");
        check(int'(voice0_active), 0, "voice0_active after disable");
        stop_voices();
        end_test("disable", err0);
    endtask

    initial begin
        void'($urandom(32'hbdfd_2c42));
        errors    = 0;
        checks    = 0;
        rst       = 1'b0;
        reg_we    = 1'b0;
        voice_sel = 1'b0;
        reg_sel   = '0;
        reg_data  = '0;
        for (int a = 0; a < 256; a++)
            mem[a] = 16'(a * 291 + 3855);
        repeat (8) @(negedge clk);
        rst = 1'b1;
        test_reset_state();
        test_single_voice();
        test_looping();
        test_mixing();
        test_read_error();
        test_disable();
        check(int'(m0_lost), 0, "port 0 reads where rready never rose");
        check(int'(m1_lost), 0, "port 1 reads where rready never rose");
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- audio_playback.f
+incdir+include
hw/audio_pkg.sv
hw/voice_reader.sv
hw/sample_mixer.sv
hw/i2s_transmitter.sv
hw/audio_playback_top.sv
verification/audio_playback_asserts.sv
verification/audio_playback_tb.sv

//--- Makefile
# Verilator build and run of the audio playback testbench

TOP := audio_playback_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator output"

test:
	verilator --binary --timing --assert -Wno-fatal -f audio_playback.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
